//--- hdl/hwcePkg.sv
// Dot-product engine shared definitions
// Default widths, command and controller encodings, accumulator sizing

`default_nettype none

package hwcePkg;

    // --------------------------------------------------
    // Default sizes, overridden from the top level
    // --------------------------------------------------

    // 16 words per memory
    localparam int DefAddrWidth  = 4;
    // Signed operand width
    localparam int DefDataWidth  = 16;
    // Results the consumer can buffer
    localparam int DefOutCredits = 2;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------

    // Command opcodes, value 3 is unused
    typedef enum logic [1:0] {
        OpLoadWeight  = 2'd0,
        OpLoadFeature = 2'd1,
        OpRun         = 2'd2
    } hwceOpE;

    // Run sequencer states
    typedef enum logic [1:0] {
        StIdle       = 2'd0,
        StWaitCredit = 2'd1,
        StRead       = 2'd2,
        StDrain      = 2'd3
    } ctrlStateE;

    // Product width plus one bit per address bit
    // Holds a sum over every word without overflow
    function automatic int accWidth(input int dataWidth, input int addrWidth);
        return 2 * dataWidth + addrWidth;
    endfunction

endpackage

`default_nettype wire

//--- hdl/registerFile1r1w.sv
// Scratch memory with one read and one write port
// Read address is registered, write data is committed at the rising edge

`default_nettype none

module registerFile1r1w
#(
    parameter int AddrWidth = 4,
    parameter int DataWidth = 16
)
(
    input  wire logic                 clk,

    // Read port
    input  wire logic                 readEnable_i,
    input  wire logic [AddrWidth-1:0] readAddr_i,
    output logic      [DataWidth-1:0] readData_o,

    // Write port
    input  wire logic                 writeEnable_i,
    input  wire logic [AddrWidth-1:0] writeAddr_i,
    input  wire logic [DataWidth-1:0] writeData_i
);

    localparam int NumWords = 2 ** AddrWidth;

    logic [DataWidth-1:0] memWords [NumWords];
    // Address register in front of the read mux
    logic [AddrWidth-1:0] readAddrQ;

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (readEnable_i)
            readAddrQ <= readAddr_i;
    end

    // Word selected by the held address
    assign readData_o = memWords[readAddrQ];

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (writeEnable_i)
            memWords[writeAddr_i] <= writeData_i;
    end

    // An undefined address would latch garbage into the read register
    readAddrKnown: assert property (@(posedge clk) readEnable_i |-> !$isunknown(readAddr_i))
        else $error("Read address has unknown bits while read is enabled");

endmodule

`default_nettype wire

//--- hdl/commandCtrl.sv
// Command decoder and run sequencer for the dot-product engine
// Turns loads into single writes and runs into wrapped read bursts
// Keeps the result credit count and retires each command with a credit pulse

`default_nettype none

module commandCtrl
    import hwcePkg::*;
#(
    parameter int AddrWidth  = DefAddrWidth,
    parameter int OutCredits = DefOutCredits
)
(
    input  wire logic                 clk,
    input  wire logic                 reset_i,

    // Command port
    input  wire logic                 cmdValid_i,
    input  wire hwceOpE               cmdOp_i,
    input  wire logic [AddrWidth-1:0] cmdAddr_i,
    input  wire logic [AddrWidth:0]   cmdLen_i,
    output logic                      cmdCredit_o,

    // Write port of both memories
    output logic                      weightWe_o,
    output logic                      featureWe_o,
    output logic      [AddrWidth-1:0] writeAddr_o,

    // Shared read port
    output logic                      readEnable_o,
    output logic      [AddrWidth-1:0] readAddr_o,

    // Accumulator markers and completion
    output logic                      macFirst_o,
    output logic                      macLast_o,
    input  wire logic                 macDone_i,

    // Result credits
    input  wire logic                 resultCredit_i,
    output logic                      resultIssue_o
);

    localparam int CreditWidth = $clog2(OutCredits + 1);

    ctrlStateE              stateQ;
    ctrlStateE              stateD;
    logic [AddrWidth-1:0]   readAddrQ;
    // Reads still to issue in the current run
    logic [AddrWidth:0]     remainQ;
    logic                   firstPendingQ;
    logic                   loadRetireQ;
    logic [CreditWidth-1:0] creditQ;
    logic                   creditFree;
    logic                   cmdReady;
    logic                   loadAccept;
    logic                   runAccept;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    // Idle, or the retiring cycle of a run
    assign cmdReady   = (stateQ == StIdle) || ((stateQ == StDrain) && macDone_i);
    assign loadAccept = cmdValid_i && (cmdOp_i != OpRun);
    assign runAccept  = cmdValid_i && (cmdOp_i == OpRun);
    assign creditFree = (creditQ != '0);

    // Loads write at the accepting edge
    assign weightWe_o  = cmdValid_i && (cmdOp_i == OpLoadWeight);
    assign featureWe_o = cmdValid_i && (cmdOp_i == OpLoadFeature);
    assign writeAddr_o = cmdAddr_i;

    // --------------------------------------------------
    // Run sequencer
    // --------------------------------------------------
    always_comb
    begin
        stateD        = stateQ;
        resultIssue_o = 1'b0;
        case (stateQ)
            StWaitCredit:
            begin
                if (creditFree)
                begin
                    resultIssue_o = 1'b1;
                    stateD        = StRead;
                end
            end
            StRead:
            begin
                if (remainQ == (AddrWidth+1)'(1))
                    stateD = StDrain;
            end
            StDrain:
            begin
                if (macDone_i)
                    stateD = StIdle;
            end
            default:
            begin
                stateD = StIdle;
            end
        endcase
        // A new run reserves its result credit up front
        if (runAccept)
        begin
            if (creditFree)
            begin
                resultIssue_o = 1'b1;
                stateD        = StRead;
            end
            else
                stateD = StWaitCredit;
        end
    end

    // Address and count, wrapping naturally at the word count
    always_ff @(posedge clk)
    begin
        if (runAccept)
        begin
            readAddrQ <= cmdAddr_i;
            remainQ   <= cmdLen_i;
        end
        else if (stateQ == StRead)
        begin
            readAddrQ <= readAddrQ + 1'b1;
            remainQ   <= remainQ - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            stateQ        <= StIdle;
            firstPendingQ <= 1'b0;
            loadRetireQ   <= 1'b0;
            creditQ       <= CreditWidth'(OutCredits);
        end
        else
        begin
            stateQ      <= stateD;
            loadRetireQ <= loadAccept;
            if (runAccept)
                firstPendingQ <= 1'b1;
            else if (stateQ == StRead)
                firstPendingQ <= 1'b0;
            // Returned credits against reserved ones
            case ({resultCredit_i, resultIssue_o})
                2'b10:   creditQ <= creditQ + 1'b1;
                2'b01:   creditQ <= creditQ - 1'b1;
                default: creditQ <= creditQ;
            endcase
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign readEnable_o = (stateQ == StRead);
    assign readAddr_o   = readAddrQ;
    assign macFirst_o   = readEnable_o && firstPendingQ;
    assign macLast_o    = readEnable_o && (remainQ == (AddrWidth+1)'(1));
    // Loads retire a cycle late, runs retire with their result
    assign cmdCredit_o  = loadRetireQ || macDone_i;

    creditBound: assert property (@(posedge clk) disable iff (reset_i)
        creditQ <= CreditWidth'(OutCredits))
        else $error("Result credit count is above OutCredits");

    creditReturn: assert property (@(posedge clk) disable iff (reset_i)
        resultCredit_i |-> (creditQ < CreditWidth'(OutCredits)))
        else $error("Result credit returned while no result was outstanding");

    // Producer holds one command credit, so no overlap
    cmdWhileBusy: assert property (@(posedge clk) disable iff (reset_i)
        cmdValid_i |-> cmdReady)
        else $error("Command arrived before the previous one retired");

endmodule

`default_nettype wire

//--- hdl/macUnit.sv
// Signed multiply-accumulate over paired weight and feature words
// One registered product stage, then a running sum released on the last product

`default_nettype none

module macUnit
    import hwcePkg::*;
#(
    parameter int AddrWidth = DefAddrWidth,
    parameter int DataWidth = DefDataWidth
)
(
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        first_i,
    input  wire logic                        last_i,
    input  wire logic signed [DataWidth-1:0] weight_i,
    input  wire logic signed [DataWidth-1:0] feature_i,
    output logic signed [accWidth(DataWidth, AddrWidth)-1:0] result_o,
    output logic                             done_o
);

    localparam int AccWidth = accWidth(DataWidth, AddrWidth);

    // Markers lined up with the read data
    logic                          firstQ;
    logic                          lastQ;
    // Product stage
    logic signed [2*DataWidth-1:0] product;
    logic signed [2*DataWidth-1:0] prodQ;
    logic                          prodFirstQ;
    logic                          prodLastQ;
    // Running sum
    logic signed [AccWidth-1:0]    accQ;
    logic signed [AccWidth-1:0]    accNext;
    logic                          inRunQ;

    assign product = weight_i * feature_i;
    // First product restarts the sum
    assign accNext = (prodFirstQ ? '0 : accQ) + AccWidth'(prodQ);

    always_ff @(posedge clk)
    begin
        prodQ <= product;
        accQ  <= accNext;
        if (prodLastQ)
            result_o <= accNext;
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            firstQ     <= 1'b0;
            lastQ      <= 1'b0;
            prodFirstQ <= 1'b0;
            prodLastQ  <= 1'b0;
            done_o     <= 1'b0;
            inRunQ     <= 1'b0;
        end
        else
        begin
            firstQ     <= first_i;
            lastQ      <= last_i;
            prodFirstQ <= firstQ;
            prodLastQ  <= lastQ;
            done_o     <= prodLastQ;
            if (prodLastQ)
                inRunQ <= 1'b0;
            else if (prodFirstQ)
                inRunQ <= 1'b1;
        end
    end

    // A sum must have been opened before it is closed
    lastAfterFirst: assert property (@(posedge clk) disable iff (reset_i)
        prodLastQ |-> (prodFirstQ || inRunQ))
        else $error("Last product seen without a first product");

endmodule

`default_nettype wire

//--- hdl/hwceDotEngine.sv
// Dot-product engine top level
// Command controller, weight and feature memories, and the accumulator

`default_nettype none

module hwceDotEngine
    import hwcePkg::*;
#(
    parameter int AddrWidth  = DefAddrWidth,
    parameter int DataWidth  = DefDataWidth,
    parameter int OutCredits = DefOutCredits
)
(
    input  wire logic                        clk,
    input  wire logic                        reset_i,

    // Command port
    input  wire logic                        cmdValid_i,
    input  wire hwceOpE                      cmdOp_i,
    input  wire logic [AddrWidth-1:0]        cmdAddr_i,
    input  wire logic [AddrWidth:0]          cmdLen_i,
    input  wire logic signed [DataWidth-1:0] cmdData_i,
    output logic                             cmdCredit_o,

    // Result port
    output logic                             resultValid_o,
    output logic signed [accWidth(DataWidth, AddrWidth)-1:0] result_o,
    input  wire logic                        resultCredit_i
);

    logic                 weightWe;
    logic                 featureWe;
    logic [AddrWidth-1:0] writeAddr;
    logic                 readEnable;
    logic [AddrWidth-1:0] readAddr;
    logic                 macFirst;
    logic                 macLast;
    logic [DataWidth-1:0] weightData;
    logic [DataWidth-1:0] featureData;

    // Credit reservation stays inside the controller
    commandCtrl #(
        .AddrWidth  (AddrWidth),
        .OutCredits (OutCredits)
    ) ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .cmdValid_i     (cmdValid_i),
        .cmdOp_i        (cmdOp_i),
        .cmdAddr_i      (cmdAddr_i),
        .cmdLen_i       (cmdLen_i),
        .cmdCredit_o    (cmdCredit_o),
        .weightWe_o     (weightWe),
        .featureWe_o    (featureWe),
        .writeAddr_o    (writeAddr),
        .readEnable_o   (readEnable),
        .readAddr_o     (readAddr),
        .macFirst_o     (macFirst),
        .macLast_o      (macLast),
        .macDone_i      (resultValid_o),
        .resultCredit_i (resultCredit_i),
        .resultIssue_o  ()
    );

    // Both memories share write address, write data and the read port
    registerFile1r1w #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) weightMem (
        .clk           (clk),
        .readEnable_i  (readEnable),
        .readAddr_i    (readAddr),
        .readData_o    (weightData),
        .writeEnable_i (weightWe),
        .writeAddr_i   (writeAddr),
        .writeData_i   (cmdData_i)
    );

    registerFile1r1w #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) featureMem (
        .clk           (clk),
        .readEnable_i  (readEnable),
        .readAddr_i    (readAddr),
        .readData_o    (featureData),
        .writeEnable_i (featureWe),
        .writeAddr_i   (writeAddr),
        .writeData_i   (cmdData_i)
    );

    macUnit #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) mac (
        .clk       (clk),
        .reset_i   (reset_i),
        .first_i   (macFirst),
        .last_i    (macLast),
        .weight_i  (weightData),
        .feature_i (featureData),
        .result_o  (result_o),
        .done_o    (resultValid_o)
    );

endmodule

`default_nettype wire

//--- verif/hwceDotEngineTb.sv
// Dot-product engine testbench
// Random loads and runs checked against a reference model
// Consumer returns result credits after random delays

`default_nettype none

module hwceDotEngineTb
    import hwcePkg::*;
();

    localparam int AddrWidth   = DefAddrWidth;
    localparam int DataWidth   = DefDataWidth;
    localparam int OutCredits  = DefOutCredits;
    localparam int AccW        = accWidth(DataWidth, AddrWidth);
    localparam int Words       = 2 ** AddrWidth;
    localparam int ResetCycles = 8;
    localparam int MaxDelay    = 6;
    localparam int RandCmds    = 60;
    localparam int HoldRuns    = 5;
    localparam int HoldCycles  = 40;
    // Fill, random mix, two wrap runs, held runs, overwrite sequence
    localparam int NumCmds     = 2 * Words + RandCmds + 2 + HoldRuns + 3;
    localparam int TimeoutCycles = 2 * (NumCmds * (Words + 2 + MaxDelay) + ResetCycles);

    typedef logic signed [AccW-1:0]      accT;
    typedef logic signed [DataWidth-1:0] dataT;

    logic                 clk;
    logic                 reset_i;
    logic                 cmdValid_i;
    hwceOpE               cmdOp_i;
    logic [AddrWidth-1:0] cmdAddr_i;
    logic [AddrWidth:0]   cmdLen_i;
    dataT                 cmdData_i;
    logic                 cmdCredit_o;
    logic                 resultValid_o;
    accT                  result_o;
    logic                 resultCredit_i;

    // Reference model state
    dataT wModel [Words];
    dataT fModel [Words];
    accT  expQ[$];
    int   returnQ[$];
    logic cmdHeld     = 1'b1;
    logic runBusy     = 1'b0;
    int   runDueIdx   = 0;
    int   loadDueIdx  = 0;
    int   outstanding = 0;
    int   holdUntil   = 0;
    int   sampleIdx   = 0;
    int   cycleCount  = 0;
    int   seed        = 32'hb7fd_b3d6;

    hwceDotEngine #(
        .AddrWidth  (AddrWidth),
        .DataWidth  (DataWidth),
        .OutCredits (OutCredits)
    ) UUT (
        .clk            (clk),
        .reset_i        (reset_i),
        .cmdValid_i     (cmdValid_i),
        .cmdOp_i        (cmdOp_i),
        .cmdAddr_i      (cmdAddr_i),
        .cmdLen_i       (cmdLen_i),
        .cmdData_i      (cmdData_i),
        .cmdCredit_o    (cmdCredit_o),
        .resultValid_o  (resultValid_o),
        .result_o       (result_o),
        .resultCredit_i (resultCredit_i)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkResult(input accT actual, input accT expected);
        if (actual !== expected)
            abortRun($sformatf("MISMATCH result_o: got 0x%h expected 0x%h", actual, expected));
    endtask

    task automatic checkCredit(input logic actual, input logic expected);
        if (actual !== expected)
            abortRun($sformatf("MISMATCH cmdCredit_o: got 0x%h expected 0x%h", actual, expected));
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic dataT randData();
        return DataWidth'($random(seed));
    endfunction

    // Signed dot product with wrap at the word count
    function automatic accT dotProduct(input int start, input int len);
        accT sum;
        accT wExt;
        accT fExt;
        int  i;
        sum = '0;
        for (i = 0; i < len; i++)
        begin
            wExt = wModel[(start + i) % Words];
            fExt = fModel[(start + i) % Words];
            sum  = sum + wExt * fExt;
        end
        return sum;
    endfunction

    // Sample and check at the falling edge, then drive the consumer
    task automatic advanceCycle();
        logic expCredit;
        @(negedge clk);
        sampleIdx++;
        expCredit = (sampleIdx == loadDueIdx);
        if (resultValid_o === 1'b1)
        begin
            if (!runBusy)
                abortRun("Result valid pulsed while no run was outstanding");
            if (runDueIdx != 0 && sampleIdx != runDueIdx)
                abortRun("Result valid came at the wrong cycle for a run with a free credit");
            checkResult(result_o, expQ.pop_front());
            // Run retires together with its result
            expCredit = 1'b1;
            runBusy   = 1'b0;
            runDueIdx = 0;
            outstanding++;
            returnQ.push_back(sampleIdx + randBelow(MaxDelay + 1));
        end
        else if (runDueIdx != 0 && sampleIdx == runDueIdx)
            abortRun("Result valid missing at the cycle the run length predicts");
        if (outstanding > OutCredits)
            abortRun("More results outstanding than the result credits allow");
        checkCredit(cmdCredit_o, expCredit);
        if (cmdCredit_o === 1'b1)
            cmdHeld = 1'b1;
        cmdValid_i     = 1'b0;
        resultCredit_i = 1'b0;
        // Consumer hands back one credit per cycle at most
        if (sampleIdx >= holdUntil && returnQ.size() > 0 && returnQ[0] <= sampleIdx)
        begin
            void'(returnQ.pop_front());
            resultCredit_i = 1'b1;
            outstanding--;
        end
    endtask

    task automatic sendCommand(input hwceOpE op, input int addr, input int len,
                               input dataT data);
        while (!cmdHeld)
            advanceCycle();
        cmdValid_i = 1'b1;
        cmdOp_i    = op;
        cmdAddr_i  = addr[AddrWidth-1:0];
        cmdLen_i   = len[AddrWidth:0];
        cmdData_i  = data;
        cmdHeld    = 1'b0;
        if (op == OpRun)
        begin
            expQ.push_back(dotProduct(addr, len));
            runBusy = 1'b1;
            // Credit seen by the DUT excludes a return driven this cycle
            if (OutCredits - outstanding - int'(resultCredit_i) > 0)
                runDueIdx = sampleIdx + len + 3;
            else
                runDueIdx = 0;
        end
        else
        begin
            if (op == OpLoadWeight)
                wModel[addr] = data;
            else
                fModel[addr] = data;
            loadDueIdx = sampleIdx + 1;
        end
        advanceCycle();
    endtask

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial
    begin
        forever
        begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > TimeoutCycles)
                abortRun("Timeout: the run did not finish within the cycle limit");
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial
    begin
        reset_i        = 1'b1;
        cmdValid_i     = 1'b0;
        cmdOp_i        = OpLoadWeight;
        cmdAddr_i      = '0;
        cmdLen_i       = '0;
        cmdData_i      = '0;
        resultCredit_i = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        // Both pulses stay low before any command
        repeat (5) advanceCycle();
        for (int i = 0; i < Words; i++)
        begin
            sendCommand(OpLoadWeight, i, 0, randData());
            sendCommand(OpLoadFeature, i, 0, randData());
        end
        for (int i = 0; i < RandCmds; i++)
        begin
            case (randBelow(4))
                0:       sendCommand(OpLoadWeight, randBelow(Words), 0, randData());
                1:       sendCommand(OpLoadFeature, randBelow(Words), 0, randData());
                default: sendCommand(OpRun, randBelow(Words), 1 + randBelow(Words), '0);
            endcase
        end
        // Ranges past the last word
        sendCommand(OpRun, Words - 3, 7, '0);
        sendCommand(OpRun, Words - 1, Words, '0);
        // Consumer withholds credits so later runs wait
        holdUntil = sampleIdx + HoldCycles;
        for (int i = 0; i < HoldRuns; i++)
            sendCommand(OpRun, randBelow(Words), 1 + randBelow(2), '0);
        // Overwrite a word inside the range of two identical runs
        sendCommand(OpRun, Words / 4, Words / 2, '0);
        sendCommand(OpLoadWeight, Words / 4 + 2, 0, ~wModel[Words / 4 + 2]);
        sendCommand(OpRun, Words / 4, Words / 2, '0);
        while (!cmdHeld)
            advanceCycle();
        if (expQ.size() == 0 && !runBusy)
        begin
            $display("Test OK");
            $finish;
        end
        else
            abortRun("Some runs ended without a result");
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/hwcePkg.sv
hdl/registerFile1r1w.sv
hdl/commandCtrl.sv
hdl/macUnit.sv
hdl/hwceDotEngine.sv
verif/hwceDotEngineTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the dot-product engine testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hwceDotEngineTb -f sim.f -Mdir obj_dir -o hwceDotEngineSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/hwceDotEngineSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

echo "Simulation finished cleanly"
exit 0
